//--- all.f
+incdir+source
source/dcache_lsu_pkg.sv
source/dcache_mem_pkg.sv
source/dcache_dpsram.sv
source/dcache_store_buffer.sv
source/dcache_lookup.sv
source/dcache_load_align.sv
source/dcache_ctrl.sv
source/dcache_top.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dcache testbench, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module dcache_tb -o sim_dcache &&
./obj_dir/sim_dcache | tee /dev/stderr | grep -qxF '>>> PASS' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- sim/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_checker
    import dcache_lsu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      req_valid_i,
    input  wire logic      req_ready_i,
    input  wire logic      resp_valid_i,
    input  wire lsu_resp_t resp_i,
    input  wire logic      resp_ready_i,
    input  wire logic      sb_full_i
);

    // a refused response stays put until taken
    resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
        else $error("response changed or dropped while ready was low");

    full_blocks_req: assert property (@(posedge clk) disable iff (!rst_n)
        sb_full_i |-> !req_ready_i)
        else $error("request accepted while the store buffer is full");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !resp_valid_i)
        else $error("response valid during reset");

    // fixed one cycle latency
    resp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid_i && req_ready_i |=> resp_valid_i)
        else $error("no response one cycle after an accepted request");

    no_spurious_resp: assert property (@(posedge clk) disable iff (!rst_n)
        !resp_valid_i && !(req_valid_i && req_ready_i) |=> !resp_valid_i)
        else $error("response appeared without an accepted request");

endmodule

`default_nettype wire

//--- sim/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb
    import dcache_lsu_pkg::*;
    import dcache_mem_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_OPS    = 90;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    lsu_req_t    req;
    logic        req_ready;
    logic        resp_valid;
    lsu_resp_t   resp;
    logic        resp_ready;
    commit_req_t commit;
    sb_entry_t   sb_head;

    // reference model
    tag_entry_t  tag_m  [`DC_WAY_NUM][`DC_SET_NUM];
    logic [31:0] data_m [`DC_WAY_NUM][`DC_SET_NUM*`DC_LINE_WORDS];
    sb_entry_t   sb_q [$];
    lsu_resp_t   exp_q [$];
    lsu_req_t    req_q [$];
    int          pending;

    integer      seed = 32'h2c40;
    logic        bp_en;
    logic [3:0]  next_id;
    logic [31:0] line_addr [8];

    dcache_top dcache_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .req_ready_o  (req_ready),
        .resp_valid_o (resp_valid),
        .resp_o       (resp),
        .resp_ready_i (resp_ready),
        .commit_i     (commit),
        .sb_head_o    (sb_head)
    );

    // full when the youngest slot of the age-ordered view is occupied
    bind dcache_top dcache_checker checker_inst (
        .clk,
        .rst_n,
        .req_valid_i,
        .req_ready_i  (req_ready_o),
        .resp_valid_i (resp_valid_o),
        .resp_i       (resp_o),
        .resp_ready_i,
        .sb_full_i    (sb_entries[`DC_SB_SIZE-1].valid)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, got);
            abort_run("value differs from the reference model");
        end
    endtask

    // expected response from model tags, data and pending stores
    function automatic lsu_resp_t predict(input lsu_req_t r);
        lsu_resp_t   p;
        logic [31:0] word;
        logic [3:0]  fwd;
        logic [7:0]  lane_b;
        logic [15:0] lane_h;
        p    = '0;
        word = '0;
        fwd  = '0;
        for (int w = 0; w < `DC_WAY_NUM; w++) begin
            p.tag_hit[w] = tag_m[w][r.addr[9:4]].valid &&
                           tag_m[w][r.addr[9:4]].tag == r.addr[31:10];
            if (p.tag_hit[w]) begin
                word        = data_m[w][r.addr[9:2]];
                p.hit_dirty = tag_m[w][r.addr[9:4]].dirty;
            end
        end
        // queue runs oldest first, so younger stores overwrite
        foreach (sb_q[i]) begin
            for (int b = 0; b < 4; b++) begin
                if (sb_q[i].addr[31:2] == r.addr[31:2] && sb_q[i].strb[b]) begin
                    word[b*8 +: 8] = sb_q[i].data[b*8 +: 8];
                    fwd[b]         = 1'b1;
                end
            end
        end
        lane_b = word[{r.addr[1:0], 3'b000} +: 8];
        lane_h = word[{r.addr[1], 4'b0000} +: 16];
        case (r.size)
            MSIZE_BYTE: p.rdata = {{24{r.msigned & lane_b[7]}}, lane_b};
            MSIZE_HALF: p.rdata = {{16{r.msigned & lane_h[15]}}, lane_h};
            default:    p.rdata = word;
        endcase
        p.hit      = (|p.tag_hit) || (r.rmask != 4'b0 && (r.rmask & ~fwd) == 4'b0);
        p.is_store = |r.strb;
        p.id       = r.id;
        return p;
    endfunction

    // model update once per cycle, inputs and outputs are settled here
    always @(negedge clk) begin
        lsu_resp_t exp_r;
        lsu_req_t  cur;
        sb_entry_t e;
        if (!rst_n) begin
            for (int w = 0; w < `DC_WAY_NUM; w++) begin
                for (int s = 0; s < `DC_SET_NUM; s++) begin
                    tag_m[w][s] = '0;
                end
                for (int i = 0; i < `DC_SET_NUM * `DC_LINE_WORDS; i++) begin
                    data_m[w][i] = '0;
                end
            end
            sb_q.delete();
            exp_q.delete();
            req_q.delete();
        end else begin
            if (sb_q.size() == 0) begin
                check_val("sb_head_o.valid", 32'(0), 32'(sb_head.valid));
            end else begin
                check_val("sb_head_o.valid", 32'(1), 32'(sb_head.valid));
                check_val("sb_head_o.addr", sb_q[0].addr, sb_head.addr);
                check_val("sb_head_o.data", sb_q[0].data, sb_head.data);
                check_val("sb_head_o.strb", 32'(sb_q[0].strb), 32'(sb_head.strb));
                check_val("sb_head_o.tag_hit", 32'(sb_q[0].tag_hit), 32'(sb_head.tag_hit));
            end
            if (sb_q.size() == `DC_SB_SIZE) begin
                check_val("req_ready_o", 32'(0), 32'(req_ready));
            end
            for (int w = 0; w < `DC_WAY_NUM; w++) begin
                if (commit.way_sel[w] && commit.tag_we) begin
                    tag_m[w][commit.addr[9:4]] = commit.payload.tag_view.tag;
                end
                for (int b = 0; b < 4; b++) begin
                    if (commit.way_sel[w] && commit.data_we && commit.strb[b]) begin
                        data_m[w][commit.addr[9:2]][b*8 +: 8] = commit.payload.word[b*8 +: 8];
                    end
                end
            end
            if (commit.sb_pop && sb_q.size() != 0) begin
                void'(sb_q.pop_front());
            end
            if (resp_valid && resp_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("response taken with no request outstanding");
                end else begin
                    exp_r = exp_q.pop_front();
                    cur   = req_q.pop_front();
                    check_val("resp_o.id", 32'(exp_r.id), 32'(resp.id));
                    check_val("resp_o.is_store", 32'(exp_r.is_store), 32'(resp.is_store));
                    check_val("resp_o.tag_hit", 32'(exp_r.tag_hit), 32'(resp.tag_hit));
                    check_val("resp_o.hit", 32'(exp_r.hit), 32'(resp.hit));
                    check_val("resp_o.hit_dirty", 32'(exp_r.hit_dirty), 32'(resp.hit_dirty));
                    if (!exp_r.is_store) begin
                        check_val("resp_o.rdata", exp_r.rdata, resp.rdata);
                    end else begin
                        e.addr    = cur.addr;
                        e.data    = cur.wdata;
                        e.strb    = cur.strb;
                        e.tag_hit = exp_r.tag_hit;
                        e.valid   = 1'b1;
                        sb_q.push_back(e);
                    end
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(predict(req));
                req_q.push_back(req);
            end
        end
        pending = exp_q.size();
    end

    // sampled before this negedge's model update
    tb_resp_order: assert property (@(negedge clk) disable iff (!rst_n)
        resp_valid |-> pending > 0)
        else abort_run("response valid with no request outstanding");

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_OPS * 20 + 10) * CLK_PERIOD);
        abort_run("timeout, the DUT stopped answering");
    end

    // random back-pressure stretches
    initial begin
        forever begin
            @(posedge clk);
            #1;
            resp_ready = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

    // call at 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic issue(input lsu_req_t r);
        req_valid = 1'b1;
        req       = r;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic load(input logic [31:0] addr, input msize_e size, input logic sgn);
        lsu_req_t r;
        r         = '0;
        r.addr    = addr;
        r.size    = size;
        r.msigned = sgn;
        r.id      = next_id;
        case (size)
            MSIZE_BYTE: r.rmask = 4'b0001 << addr[1:0];
            MSIZE_HALF: r.rmask = 4'b0011 << {addr[1], 1'b0};
            default:    r.rmask = 4'b1111;
        endcase
        next_id++;
        issue(r);
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] strb);
        lsu_req_t r;
        r       = '0;
        r.addr  = addr;
        r.wdata = data;
        r.strb  = strb;
        r.size  = MSIZE_WORD;
        r.id    = next_id;
        next_id++;
        issue(r);
    endtask

    task automatic commit_cycle(input commit_req_t c);
        commit = c;
        @(posedge clk);
        #1;
        commit = '0;
    endtask

    task automatic fill_line(input int way, input logic [31:0] addr, input logic [31:0] data);
        commit_req_t c;
        c                           = '0;
        c.addr                      = addr;
        c.way_sel[way]              = 1'b1;
        c.tag_we                    = 1'b1;
        c.payload.tag_view.tag.tag   = addr[31:10];
        c.payload.tag_view.tag.valid = 1'b1;
        c.payload.tag_view.tag.dirty = (way == 1);
        commit_cycle(c);
        c.tag_we       = 1'b0;
        c.data_we      = 1'b1;
        c.strb         = 4'hf;
        c.payload.word = data;
        commit_cycle(c);
    endtask

    task automatic pop_sb();
        commit_req_t c;
        c        = '0;
        c.sb_pop = 1'b1;
        commit_cycle(c);
    endtask

    task automatic drain();
        while (pending != 0 || resp_valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        commit_req_t c;
        logic [31:0] a;
        int          k;
        logic [1:0]  off;
        msize_e      sz;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        commit     = '0;
        bp_en      = 1'b0;
        next_id    = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // one line per set, ways alternate
        for (int i = 0; i < 8; i++) begin
            line_addr[i] = {22'($random(seed)), 6'(i * 7 + 1), 2'($random(seed)), 2'b00};
            fill_line(i % 2, line_addr[i], $random(seed));
            load(line_addr[i], MSIZE_WORD, 1'b0);
            drain();
        end
        // set 63 never filled
        load({22'h0, 6'd63, 4'h0}, MSIZE_WORD, 1'b0);

        // sign bits set in both bytes and halves
        fill_line(0, line_addr[0], 32'h80f7_7f81);
        for (int s = 1; s >= 0; s--) begin
            for (int b = 0; b < 4; b++) begin
                load(line_addr[0] + 32'(b), MSIZE_BYTE, s[0]);
            end
            for (int h = 0; h < 2; h++) begin
                load(line_addr[0] + 32'(2 * h), MSIZE_HALF, s[0]);
            end
        end
        drain();

        // forwarding over a hit, then over a miss
        store(line_addr[1], $random(seed), 4'b0110);
        load(line_addr[1], MSIZE_WORD, 1'b0);
        a = {22'($random(seed)), 6'd62, 2'd1, 2'b00};
        store(a, $random(seed), 4'hf);
        load(a + 32'd3, MSIZE_BYTE, 1'b1);
        load(a, MSIZE_WORD, 1'b0);
        drain();
        pop_sb();
        pop_sb();

        // fill the buffer without popping
        for (int i = 0; i < `DC_SB_SIZE; i++) begin
            store(line_addr[i + 2], $random(seed), 4'($random(seed)) | 4'b0001);
        end
        drain();
        check_val("req_ready_o", 32'(0), 32'(req_ready));
        for (int i = 0; i < `DC_SB_SIZE; i++) begin
            pop_sb();
        end

        // mixed traffic under back-pressure
        bp_en = 1'b1;
        for (int i = 0; i < 24; i++) begin
            k = $unsigned($random(seed)) % 8;
            if (i % 8 == 3) begin
                store(line_addr[k], $random(seed), 4'b0011 << {1'b0, k[0]});
            end else begin
                sz  = msize_e'(2'($unsigned($random(seed)) % 3));
                off = 2'($random(seed));
                if (sz == MSIZE_HALF) begin
                    off[0] = 1'b0;
                end else if (sz == MSIZE_WORD) begin
                    off = 2'b00;
                end
                a = {line_addr[k][31:4], 2'($random(seed)), off};
                load(a, sz, k[1]);
            end
        end
        drain();
        bp_en = 1'b0;
        for (int i = 0; i < 3; i++) begin
            pop_sb();
        end

        // commit write in the accepting cycle reaches the load
        drain();
        c              = '0;
        c.addr         = line_addr[2];
        c.way_sel[0]   = 1'b1;
        c.data_we      = 1'b1;
        c.strb         = 4'b1010;
        c.payload.word = $random(seed);
        commit         = c;
        load(line_addr[2], MSIZE_WORD, 1'b0);
        commit = '0;
        drain();

        if (pending == 0 && sb_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("requests or stores left over at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_ctrl
    import dcache_lsu_pkg::*;
    import dcache_mem_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        req_valid_i,
    input  wire lsu_req_t                    req_i,
    output logic                             req_ready_o,
    output logic                             resp_valid_o,
    output lsu_resp_t                        resp_o,
    input  wire logic                        resp_ready_i,
    output logic                             rd_en_o,
    output logic      [31:0]                 rd_addr_o,
    output lsu_req_t                         m1_req_o,
    input  wire logic [31:0]                 load_data_i,
    input  wire logic                        load_hit_i,
    input  wire logic [`DC_WAY_NUM-1:0]      tag_hit_i,
    input  wire logic                        hit_dirty_i,
    input  wire logic                        sb_full_i,
    output logic                             sb_push_o,
    output sb_entry_t                        sb_entry_o
);

    logic      hold;
    logic      req_fire;
    logic      resp_fire;
    logic      held_q;
    lsu_resp_t resp_now;
    lsu_resp_t resp_q;

    assign hold        = resp_valid_o && !resp_ready_i;
    assign resp_fire   = resp_valid_o && resp_ready_i;
    assign req_ready_o = !hold && !sb_full_i;
    assign req_fire    = req_valid_i && req_ready_o;

    // re-read the M1 line while the response waits
    assign rd_en_o   = req_fire || hold;
    assign rd_addr_o = hold ? m1_req_o.addr : req_i.addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid_o <= 1'b0;
            held_q       <= 1'b0;
        end else begin
            if (req_fire) begin
                resp_valid_o <= 1'b1;
            end else if (resp_fire) begin
                resp_valid_o <= 1'b0;
            end
            held_q <= hold;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            m1_req_o <= req_i;
        end
        if (hold) begin
            resp_q <= resp_o;
        end
    end

    always_comb begin
        resp_now.rdata     = load_data_i;
        resp_now.hit       = load_hit_i;
        resp_now.tag_hit   = tag_hit_i;
        resp_now.hit_dirty = hit_dirty_i;
        resp_now.is_store  = |m1_req_o.strb;
        resp_now.id        = m1_req_o.id;
    end

    // frozen copy once the response has been refused
    assign resp_o = held_q ? resp_q : resp_now;

    assign sb_push_o          = resp_fire && (|m1_req_o.strb);
    assign sb_entry_o.addr    = m1_req_o.addr;
    assign sb_entry_o.data    = m1_req_o.wdata;
    assign sb_entry_o.strb    = m1_req_o.strb;
    assign sb_entry_o.tag_hit = resp_o.tag_hit;
    assign sb_entry_o.valid   = 1'b1;

endmodule

`default_nettype wire

//--- source/dcache_dpsram.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_dpsram #(
    parameter int unsigned DATA_W = 32,
    parameter int unsigned DEPTH  = 256,
    parameter int unsigned BYTE_W = 8
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       rd_en_i,
    input  wire logic [$clog2(DEPTH)-1:0]   rd_addr_i,
    output logic      [DATA_W-1:0]          rd_data_o,
    input  wire logic [DATA_W/BYTE_W-1:0]   wr_be_i,
    input  wire logic [$clog2(DEPTH)-1:0]   wr_addr_i,
    input  wire logic [DATA_W-1:0]          wr_data_i
);

    localparam int unsigned BE_W = DATA_W / BYTE_W;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [DATA_W-1:0] rd_next;

    // write-first: bytes written this cycle reach the reader
    always_comb begin
        rd_next = mem[rd_addr_i];
        for (int b = 0; b < BE_W; b++) begin
            if (wr_be_i[b] && wr_addr_i == rd_addr_i) begin
                rd_next[b*BYTE_W +: BYTE_W] = wr_data_i[b*BYTE_W +: BYTE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_data_o <= '0;
        end else begin
            for (int b = 0; b < BE_W; b++) begin
                if (wr_be_i[b]) begin
                    mem[wr_addr_i][b*BYTE_W +: BYTE_W] <= wr_data_i[b*BYTE_W +: BYTE_W];
                end
            end
            if (rd_en_i) begin
                rd_data_o <= rd_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_load_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_load_align
    import dcache_lsu_pkg::*;
(
    input  wire lsu_req_t                 req_i,
    input  wire logic [31:0]              merged_i,
    input  wire logic [3:0]               fwd_mask_i,
    input  wire logic [`DC_WAY_NUM-1:0]   tag_hit_i,
    output logic      [31:0]              load_data_o,
    output logic                          load_hit_o
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // the read mask names the lane
    always_comb begin
        sel_byte = '0;
        sel_half = '0;
        for (int b = 0; b < 4; b++) begin
            if (req_i.rmask[b]) begin
                sel_byte = merged_i[b*8 +: 8];
            end
        end
        for (int h = 0; h < 2; h++) begin
            if (req_i.rmask[2*h]) begin
                sel_half = merged_i[h*16 +: 16];
            end
        end
    end

    always_comb begin
        case (req_i.size)
            MSIZE_BYTE: load_data_o = {{24{req_i.msigned && sel_byte[7]}}, sel_byte};
            MSIZE_HALF: load_data_o = {{16{req_i.msigned && sel_half[15]}}, sel_half};
            default:    load_data_o = merged_i;
        endcase
    end

    // a miss still counts when the buffer covers every read byte
    assign load_hit_o = (|tag_hit_i) ||
                        ((|req_i.rmask) && ((req_i.rmask & fwd_mask_i) == req_i.rmask));

endmodule

`default_nettype wire

//--- source/dcache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_lookup
    import dcache_mem_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          rd_en_i,
    input  wire logic [31:0]                   rd_addr_i,
    input  wire logic [31:0]                   m1_addr_i,
    input  wire commit_req_t                   commit_i,
    input  wire sb_entry_t [`DC_SB_SIZE-1:0]   sb_entries_i,
    output logic      [31:0]                   merged_o,
    output logic      [3:0]                    fwd_mask_o,
    output logic      [`DC_WAY_NUM-1:0]        tag_hit_o,
    output logic                               hit_dirty_o
);

    tag_entry_t  rd_tag  [`DC_WAY_NUM];
    logic [31:0] rd_word [`DC_WAY_NUM];
    logic [31:0] way_word;
    logic [31:0] fwd_word;

    for (genvar w = 0; w < `DC_WAY_NUM; w++) begin : g_way
        logic       tag_we;
        logic [3:0] data_be;

        assign tag_we  = commit_i.way_sel[w] && commit_i.tag_we;
        assign data_be = {4{commit_i.way_sel[w] && commit_i.data_we}} & commit_i.strb;

        dcache_dpsram #(
            .DATA_W ($bits(tag_entry_t)),
            .DEPTH  (`DC_SET_NUM),
            .BYTE_W ($bits(tag_entry_t))
        ) tag_ram (
            .clk,
            .rst_n,
            .rd_en_i   (rd_en_i),
            .rd_addr_i (rd_addr_i[`DC_TAG_LO-1:`DC_IDX_LO]),
            .rd_data_o (rd_tag[w]),
            .wr_be_i   (tag_we),
            .wr_addr_i (commit_i.addr[`DC_TAG_LO-1:`DC_IDX_LO]),
            .wr_data_i (commit_i.payload.tag_view.tag)
        );

        // one word per entry, indexed by set and word offset
        dcache_dpsram #(
            .DATA_W (32),
            .DEPTH  (`DC_SET_NUM * `DC_LINE_WORDS),
            .BYTE_W (8)
        ) data_ram (
            .clk,
            .rst_n,
            .rd_en_i   (rd_en_i),
            .rd_addr_i (rd_addr_i[`DC_TAG_LO-1:`DC_WORD_LO]),
            .rd_data_o (rd_word[w]),
            .wr_be_i   (data_be),
            .wr_addr_i (commit_i.addr[`DC_TAG_LO-1:`DC_WORD_LO]),
            .wr_data_i (commit_i.payload.word)
        );
    end

    always_comb begin
        way_word    = '0;
        tag_hit_o   = '0;
        hit_dirty_o = 1'b0;
        for (int w = 0; w < `DC_WAY_NUM; w++) begin
            tag_hit_o[w] = rd_tag[w].valid && rd_tag[w].tag == m1_addr_i[31:`DC_TAG_LO];
            if (tag_hit_o[w]) begin
                way_word    = way_word | rd_word[w];
                hit_dirty_o = hit_dirty_o | rd_tag[w].dirty;
            end
        end
    end

    // walk from oldest to newest so younger stores win
    always_comb begin
        fwd_mask_o = '0;
        fwd_word   = '0;
        for (int i = 0; i < `DC_SB_SIZE; i++) begin
            for (int b = 0; b < 4; b++) begin
                if (sb_entries_i[i].valid && sb_entries_i[i].strb[b] &&
                    sb_entries_i[i].addr[31:2] == m1_addr_i[31:2]) begin
                    fwd_mask_o[b]      = 1'b1;
                    fwd_word[b*8 +: 8] = sb_entries_i[i].data[b*8 +: 8];
                end
            end
        end
        for (int b = 0; b < 4; b++) begin
            merged_o[b*8 +: 8] = fwd_mask_o[b] ? fwd_word[b*8 +: 8] : way_word[b*8 +: 8];
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_lsu_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_lsu_pkg;

    // access size of a load or store
    typedef enum logic [1:0] {
        MSIZE_BYTE = 2'd0,
        MSIZE_HALF = 2'd1,
        MSIZE_WORD = 2'd2
    } msize_e;

    // request from the cpu side, strb != 0 marks a store
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [3:0]  rmask;
        msize_e      size;
        logic        msigned;
        logic [3:0]  id;
    } lsu_req_t;

    // response back to the cpu side
    typedef struct packed {
        logic [31:0]            rdata;
        logic                   hit;
        logic [`DC_WAY_NUM-1:0] tag_hit;
        logic                   hit_dirty;
        logic                   is_store;
        logic [3:0]             id;
    } lsu_resp_t;

endpackage

`default_nettype wire

//--- source/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry
`define DC_WAY_NUM      2
`define DC_SET_NUM      64
`define DC_LINE_WORDS   4
`define DC_SB_SIZE      4

// derived index widths
`define DC_IDX_W        $clog2(`DC_SET_NUM)
`define DC_WORD_IDX_W   $clog2(`DC_LINE_WORDS)

// address split: word offset 3:2, set index 9:4, tag 31:10
`define DC_WORD_LO      2
`define DC_IDX_LO       (`DC_WORD_LO + `DC_WORD_IDX_W)
`define DC_TAG_LO       (`DC_IDX_LO + `DC_IDX_W)
`define DC_TAG_W        (32 - `DC_TAG_LO)

`endif

//--- source/dcache_mem_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_mem_pkg;

    typedef struct packed {
        logic [`DC_TAG_W-1:0] tag;
        logic                 valid;
        logic                 dirty;
    } tag_entry_t;

    // pending store, tag_hit recorded at lookup time
    typedef struct packed {
        logic [31:0]            addr;
        logic [31:0]            data;
        logic [3:0]             strb;
        logic [`DC_WAY_NUM-1:0] tag_hit;
        logic                   valid;
    } sb_entry_t;

    // tag entry padded up to one word
    typedef struct packed {
        logic [31-$bits(tag_entry_t):0] pad;
        tag_entry_t                     tag;
    } tag_word_t;

    // commit payload, tag_we picks the tag view
    typedef union packed {
        tag_word_t   tag_view;
        logic [31:0] word;
    } commit_payload_u;

    typedef struct packed {
        logic [31:0]            addr;
        logic [`DC_WAY_NUM-1:0] way_sel;
        logic                   tag_we;
        logic                   data_we;
        logic [3:0]             strb;
        commit_payload_u        payload;
        logic                   sb_pop;
    } commit_req_t;

endpackage

`default_nettype wire

//--- source/dcache_store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_store_buffer
    import dcache_mem_pkg::*;
#(
    parameter int unsigned SB_SIZE = 4
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      push_i,
    input  wire sb_entry_t                 push_entry_i,
    input  wire logic                      pop_i,
    output sb_entry_t                      head_o,
    output sb_entry_t [SB_SIZE-1:0]        entries_o,
    output logic                           full_o,
    output logic                           empty_o
);

    localparam int unsigned PTR_W = (SB_SIZE > 1) ? $clog2(SB_SIZE) : 1;
    localparam int unsigned CNT_W = $clog2(SB_SIZE + 1);

    sb_entry_t        slots [SB_SIZE];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_next;
    logic             pop_ok;
    logic             push_ok;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(SB_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o    = (count_q == '0);
    assign pop_ok     = pop_i && !empty_o;
    // a push into a full buffer only lands when a pop frees a slot
    assign push_ok    = push_i && (count_q != CNT_W'(SB_SIZE) || pop_ok);
    assign count_next = count_q + CNT_W'(push_ok) - CNT_W'(pop_ok);

    // also high when this cycle's push fills the last slot
    assign full_o = (count_q == CNT_W'(SB_SIZE)) || (count_next == CNT_W'(SB_SIZE));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_ok) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (pop_ok) begin
                head_q <= ptr_inc(head_q);
            end
            count_q <= count_next;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            slots[tail_q] <= push_entry_i;
        end
    end

    // oldest entry first, valid from the occupancy count
    always_comb begin
        for (int i = 0; i < SB_SIZE; i++) begin
            entries_o[i]       = slots[(int'(head_q) + i) % SB_SIZE];
            entries_o[i].valid = (i < int'(count_q));
        end
    end

    assign head_o = entries_o[0];

endmodule

`default_nettype wire

//--- source/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_top
    import dcache_lsu_pkg::*;
    import dcache_mem_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          req_valid_i,
    input  wire lsu_req_t      req_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output lsu_resp_t          resp_o,
    input  wire logic          resp_ready_i,
    input  wire commit_req_t   commit_i,
    output sb_entry_t          sb_head_o
);

    logic                          rd_en;
    logic [31:0]                   rd_addr;
    lsu_req_t                      m1_req;
    logic [31:0]                   merged;
    logic [3:0]                    fwd_mask;
    logic [`DC_WAY_NUM-1:0]        tag_hit;
    logic                          hit_dirty;
    logic [31:0]                   load_data;
    logic                          load_hit;
    logic                          sb_full;
    logic                          sb_push;
    sb_entry_t                     sb_entry;
    sb_entry_t [`DC_SB_SIZE-1:0]   sb_entries;

    dcache_ctrl ctrl_inst (
        .clk,
        .rst_n,
        .req_valid_i,
        .req_i,
        .req_ready_o,
        .resp_valid_o,
        .resp_o,
        .resp_ready_i,
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .m1_req_o    (m1_req),
        .load_data_i (load_data),
        .load_hit_i  (load_hit),
        .tag_hit_i   (tag_hit),
        .hit_dirty_i (hit_dirty),
        .sb_full_i   (sb_full),
        .sb_push_o   (sb_push),
        .sb_entry_o  (sb_entry)
    );

    dcache_lookup lookup_inst (
        .clk,
        .rst_n,
        .rd_en_i      (rd_en),
        .rd_addr_i    (rd_addr),
        .m1_addr_i    (m1_req.addr),
        .commit_i,
        .sb_entries_i (sb_entries),
        .merged_o     (merged),
        .fwd_mask_o   (fwd_mask),
        .tag_hit_o    (tag_hit),
        .hit_dirty_o  (hit_dirty)
    );

    dcache_load_align align_inst (
        .req_i       (m1_req),
        .merged_i    (merged),
        .fwd_mask_i  (fwd_mask),
        .tag_hit_i   (tag_hit),
        .load_data_o (load_data),
        .load_hit_o  (load_hit)
    );

    // a pop on an empty buffer is dropped inside the FIFO
    dcache_store_buffer #(
        .SB_SIZE (`DC_SB_SIZE)
    ) sb_inst (
        .clk,
        .rst_n,
        .push_i       (sb_push),
        .push_entry_i (sb_entry),
        .pop_i        (commit_i.sb_pop),
        .head_o       (sb_head_o),
        .entries_o    (sb_entries),
        .full_o       (sb_full),
        .empty_o      ()
    );

endmodule

`default_nettype wire
